//--- cache_pkg.sv
package cache_pkg;

	//////////////////////////////////////////////////
	// Address and data widths
	//////////////////////////////////////////////////

	localparam int ADDR_W = 16;
	localparam int WORD_W = 16;

	// Field widths of a byte address, bit 0 ignored
	localparam int TAG_W    = 6;
	localparam int INDEX_W  = 6;
	localparam int OFFSET_W = 3;

	// Cache geometry
	localparam int NUM_SETS        = 64;
	localparam int NUM_WAYS        = 2;
	localparam int WORDS_PER_BLOCK = 8;

	// Main memory, one word per half-address
	localparam int MEM_LATENCY = 4;
	localparam int MEM_DEPTH   = 32768;

	typedef logic [ADDR_W-1:0]   addr_t;
	typedef logic [WORD_W-1:0]   word_t;
	typedef logic [TAG_W-1:0]    tag_t;
	typedef logic [INDEX_W-1:0]  index_t;
	typedef logic [OFFSET_W-1:0] offset_t;

	//////////////////////////////////////////////////
	// Bundles between the blocks
	//////////////////////////////////////////////////

	// One processor port request
	typedef struct packed {
		logic  read;
		logic  write;
		addr_t addr;
		word_t wdata;
	} cpu_req_t;

	// One word of a block fill, last marks word 7 and installs the tag
	typedef struct packed {
		logic  valid;
		addr_t addr;
		word_t data;
		logic  last;
	} fill_write_t;

	typedef struct packed {
		logic  enable;
		logic  wr;
		addr_t addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic  valid;
		word_t data;
	} mem_rsp_t;

	// Field extraction, tag [15:10] index [9:4] word [3:1]
	function automatic tag_t get_tag(addr_t addr);
		return addr[ADDR_W-1 -: TAG_W];
	endfunction

	function automatic index_t get_index(addr_t addr);
		return addr[OFFSET_W+1 +: INDEX_W];
	endfunction

	function automatic offset_t get_offset(addr_t addr);
		return addr[1 +: OFFSET_W];
	endfunction

	// Byte address of one word inside the block holding addr
	function automatic addr_t block_word_addr(addr_t addr, offset_t offset);
		return {addr[ADDR_W-1:OFFSET_W+1], offset, 1'b0};
	endfunction

	// Word index into main memory
	function automatic logic [ADDR_W-2:0] mem_index(addr_t addr);
		return addr[ADDR_W-1:1];
	endfunction

endpackage

//--- set_assoc_cache.sv
`timescale 1ns/10ps

module set_assoc_cache import cache_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  cpu_req_t    req,
	input  fill_write_t fill,
	output word_t       rdata,
	output logic        miss,
	output logic        store_hit
);

	// Tag and data storage, no reset
	tag_t  tag_mem  [NUM_SETS][NUM_WAYS];
	word_t data_mem [NUM_SETS][NUM_WAYS][WORDS_PER_BLOCK];

	// Valid per way and one LRU bit per set
	// LRU bit holds the way that was used least recently
	logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_bits;
	logic [NUM_SETS-1:0]               lru_way;

	// Request side
	tag_t                req_tag;
	index_t              req_index;
	offset_t             req_offset;
	logic [NUM_WAYS-1:0] way_hit;
	logic                hit;
	logic                hit_sel;
	logic                access;

	// Fill side
	tag_t    fill_tag;
	index_t  fill_index;
	offset_t fill_offset;
	logic    fill_active;
	logic    victim_now;
	logic    victim_q;
	logic    fill_sel;

	assign req_tag    = get_tag(req.addr);
	assign req_index  = get_index(req.addr);
	assign req_offset = get_offset(req.addr);

	//////////////////////////////////////////////////
	// Hit check and read mux
	//////////////////////////////////////////////////

	always_comb begin
		for (int w = 0; w < NUM_WAYS; w++) begin
			way_hit[w] = valid_bits[req_index][w] && (tag_mem[req_index][w] == req_tag);
		end
	end

	assign hit     = |way_hit;
	// Only two ways, way 1 match picks way 1
	assign hit_sel = way_hit[1];
	assign access  = req.read | req.write;

	assign miss      = access & ~hit;
	assign store_hit = req.write & hit;

	// Zero when nothing matches
	assign rdata = hit ? data_mem[req_index][hit_sel][req_offset] : '0;

	//////////////////////////////////////////////////
	// Victim selection for a fill
	//////////////////////////////////////////////////

	assign fill_tag    = get_tag(fill.addr);
	assign fill_index  = get_index(fill.addr);
	assign fill_offset = get_offset(fill.addr);

	// Empty way 0 first, then empty way 1, then the LRU way
	always_comb begin
		if (!valid_bits[fill_index][0]) begin
			victim_now = 1'b0;
		end else if (!valid_bits[fill_index][1]) begin
			victim_now = 1'b1;
		end else begin
			victim_now = lru_way[fill_index];
		end
	end

	// First word decides, later words reuse the latched way
	assign fill_sel = fill_active ? victim_q : victim_now;

	//////////////////////////////////////////////////
	// Control state, valid and LRU
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_bits  <= '0;
			lru_way     <= '0;
			fill_active <= 1'b0;
			victim_q    <= 1'b0;
		end else begin
			if (fill.valid) begin
				if (!fill_active) begin
					victim_q <= victim_now;
				end
				fill_active <= ~fill.last;
				// Last word makes the block live and most recently used
				if (fill.last) begin
					valid_bits[fill_index][fill_sel] <= 1'b1;
					lru_way[fill_index]              <= ~fill_sel;
				end
			end else if (access && hit) begin
				// Other way becomes least recently used
				lru_way[req_index] <= ~hit_sel;
			end
		end
	end

	//////////////////////////////////////////////////
	// Data and tag writes
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		// Fill words land one per arrival
		if (fill.valid) begin
			data_mem[fill_index][fill_sel][fill_offset] <= fill.data;
		end
		if (fill.valid && fill.last) begin
			tag_mem[fill_index][fill_sel] <= fill_tag;
		end
		// Store hit writes the matching way, memory is written at the same edge
		if (store_hit) begin
			data_mem[req_index][hit_sel][req_offset] <= req.wdata;
		end
	end

endmodule

//--- cache_fill_fsm.sv
`timescale 1ns/10ps

module cache_fill_fsm import cache_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        instr_miss,
	input  addr_t       instr_addr,
	input  logic        data_miss,
	input  addr_t       data_addr,
	output mem_req_t    mem_req,
	input  mem_rsp_t    mem_rsp,
	output fill_write_t instr_fill,
	output fill_write_t data_fill,
	output logic        busy
);

	// Served port, 1 for the instruction cache
	logic        serve_instr;
	addr_t       block_addr;
	logic        accept;

	// Issue side and return side count separately
	// so several reads sit in the memory pipeline at once
	logic        issuing;
	offset_t     issue_cnt;
	offset_t     rsp_cnt;
	logic        issue_last;
	logic        rsp_last;
	fill_write_t word_fill;

	// Idle engine takes a miss, instruction side first
	assign accept = ~busy & (instr_miss | data_miss);

	assign issue_last = (issue_cnt == offset_t'(WORDS_PER_BLOCK - 1));
	assign rsp_last   = (rsp_cnt == offset_t'(WORDS_PER_BLOCK - 1));

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			busy        <= 1'b0;
			serve_instr <= 1'b0;
			issuing     <= 1'b0;
			issue_cnt   <= '0;
			rsp_cnt     <= '0;
		end else if (accept) begin
			busy        <= 1'b1;
			serve_instr <= instr_miss;
			issuing     <= 1'b1;
			issue_cnt   <= '0;
			rsp_cnt     <= '0;
		end else if (busy) begin
			// One address per cycle, words 0 to 7
			if (issuing) begin
				issue_cnt <= issue_cnt + 1'b1;
				if (issue_last) begin
					issuing <= 1'b0;
				end
			end
			// Done with the eighth returned word
			if (mem_rsp.valid) begin
				rsp_cnt <= rsp_cnt + 1'b1;
				if (rsp_last) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// Block base of the winning miss
	always_ff @(posedge clk) begin
		if (accept) begin
			block_addr <= block_word_addr(instr_miss ? instr_addr : data_addr, '0);
		end
	end

	//////////////////////////////////////////////////
	// Memory reads and fill routing
	//////////////////////////////////////////////////

	always_comb begin
		mem_req.enable = issuing;
		mem_req.wr     = 1'b0;
		mem_req.addr   = block_word_addr(block_addr, issue_cnt);
		mem_req.wdata  = '0;
	end

	// Each returned word carries its own address
	always_comb begin
		word_fill.valid = busy & mem_rsp.valid;
		word_fill.addr  = block_word_addr(block_addr, rsp_cnt);
		word_fill.data  = mem_rsp.data;
		word_fill.last  = rsp_last;
	end

	// Only the served cache sees valid
	always_comb begin
		instr_fill       = word_fill;
		data_fill        = word_fill;
		instr_fill.valid = word_fill.valid & serve_instr;
		data_fill.valid  = word_fill.valid & ~serve_instr;
	end

endmodule

//--- main_memory.sv
`timescale 1ns/10ps

module main_memory import cache_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  mem_req_t req,
	output mem_rsp_t rsp
);

	// Word array, starts at zero and keeps its contents through reset
	word_t mem_array [MEM_DEPTH];

	// Read pipeline, one stage per latency cycle
	logic [MEM_LATENCY-1:0] pipe_valid;
	addr_t                  pipe_addr [MEM_LATENCY];
	logic                   rd_issue;
	logic                   wr_issue;

	assign rd_issue = req.enable & ~req.wr;
	assign wr_issue = req.enable & req.wr;

	initial begin
		for (int i = 0; i < MEM_DEPTH; i++) begin
			mem_array[i] = '0;
		end
	end

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////

	// Single cycle write, no response
	always @(posedge clk) begin
		if (wr_issue) begin
			mem_array[mem_index(req.addr)] <= req.wdata;
		end
	end

	//////////////////////////////////////////////////
	// Read pipeline
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid <= {pipe_valid[MEM_LATENCY-2:0], rd_issue};
		end
	end

	// Address rides along with its valid
	always_ff @(posedge clk) begin
		pipe_addr[0] <= req.addr;
		for (int s = 1; s < MEM_LATENCY; s++) begin
			pipe_addr[s] <= pipe_addr[s-1];
		end
	end

	// Word comes out MEM_LATENCY cycles after the read was issued
	assign rsp.valid = pipe_valid[MEM_LATENCY-1];
	assign rsp.data  = mem_array[mem_index(pipe_addr[MEM_LATENCY-1])];

endmodule

//--- memory_system.sv
`timescale 1ns/10ps

module memory_system import cache_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  cpu_req_t instr_req,
	output word_t    instr_rdata,
	output logic     instr_stall,
	input  cpu_req_t data_req,
	output word_t    data_rdata,
	output logic     data_stall
);

	logic        instr_miss;
	logic        data_miss;
	logic        data_store_hit;
	logic        fill_busy;
	fill_write_t instr_fill;
	fill_write_t data_fill;
	mem_req_t    fill_mem_req;
	mem_req_t    store_mem_req;
	mem_req_t    mem_req;
	mem_rsp_t    mem_rsp;

	//////////////////////////////////////////////////
	// Split L1, instruction side never stores
	//////////////////////////////////////////////////

	set_assoc_cache instr_cache_inst (
		.clk       (clk),
		.reset     (reset),
		.req       (instr_req),
		.fill      (instr_fill),
		.rdata     (instr_rdata),
		.miss      (instr_miss),
		.store_hit ()
	);

	set_assoc_cache data_cache_inst (
		.clk       (clk),
		.reset     (reset),
		.req       (data_req),
		.fill      (data_fill),
		.rdata     (data_rdata),
		.miss      (data_miss),
		.store_hit (data_store_hit)
	);

	// Shared refill engine, instruction miss wins a tie
	cache_fill_fsm fill_fsm_inst (
		.clk        (clk),
		.reset      (reset),
		.instr_miss (instr_miss),
		.instr_addr (instr_req.addr),
		.data_miss  (data_miss),
		.data_addr  (data_req.addr),
		.mem_req    (fill_mem_req),
		.mem_rsp    (mem_rsp),
		.instr_fill (instr_fill),
		.data_fill  (data_fill),
		.busy       (fill_busy)
	);

	main_memory main_memory_inst (
		.clk   (clk),
		.reset (reset),
		.req   (mem_req),
		.rsp   (mem_rsp)
	);

	// Write-through of a data store hit
	assign store_mem_req = '{enable: data_store_hit, wr: 1'b1,
		addr: data_req.addr, wdata: data_req.wdata};

	// Fill engine owns the memory port while busy
	assign mem_req = fill_busy ? fill_mem_req : store_mem_req;

	// Stall on own miss or on any request during a fill
	assign instr_stall = instr_miss | (fill_busy & (instr_req.read | instr_req.write));
	assign data_stall  = data_miss | (fill_busy & (data_req.read | data_req.write));

endmodule

//--- memory_system_assertions.sv
`timescale 1ns/10ps

module memory_system_assertions import cache_pkg::*; (
	input logic        clk,
	input logic        reset,
	input logic        busy,
	input mem_req_t    mem_req,
	input mem_rsp_t    mem_rsp,
	input fill_write_t instr_fill,
	input fill_write_t data_fill
);

	// Eight issues plus the latency, the acceptance cycle comes before busy
	localparam int BUSY_CYCLES = MEM_LATENCY + WORDS_PER_BLOCK;

	logic  fill_any;
	logic  fill_last;
	addr_t fill_addr;
	int    busy_len;

	// Both fill buses carry the same word, only valid differs
	assign fill_any  = instr_fill.valid | data_fill.valid;
	assign fill_addr = instr_fill.valid ? instr_fill.addr : data_fill.addr;
	assign fill_last = instr_fill.valid ? instr_fill.last : data_fill.last;

	// Length of the current busy run
	always_ff @(posedge clk) begin
		if (reset) begin
			busy_len <= 0;
		end else if (busy) begin
			busy_len <= busy_len + 1;
		end else begin
			busy_len <= 0;
		end
	end

	//////////////////////////////////////////////////
	// Fill engine properties
	//////////////////////////////////////////////////

	read_in_fill: assert property (@(posedge clk) disable iff (reset)
		(mem_req.enable && !mem_req.wr) |-> busy)
		else $error("memory read issued while the fill engine is idle");

	// Words return back to back, one word apart
	fill_addr_step: assert property (@(posedge clk) disable iff (reset)
		(fill_any && !fill_last) |=> (fill_any && fill_addr == $past(fill_addr) + 16'd2))
		else $error("fill word address does not follow the previous one");

	one_fill_target: assert property (@(posedge clk) disable iff (reset)
		mem_rsp.valid |-> (instr_fill.valid ^ data_fill.valid))
		else $error("returned word routed to no cache or to both");

	busy_length: assert property (@(posedge clk) disable iff (reset)
		$fell(busy) |-> (busy_len == BUSY_CYCLES))
		else $error("fill engine busy run has the wrong length");

endmodule

bind cache_fill_fsm memory_system_assertions fill_checks_inst (
	.clk        (clk),
	.reset      (reset),
	.busy       (busy),
	.mem_req    (mem_req),
	.mem_rsp    (mem_rsp),
	.instr_fill (instr_fill),
	.data_fill  (data_fill)
);

//--- tb_memory_system.sv
`timescale 1ns/10ps

module tb_memory_system
	import cache_pkg::*;
();

	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 8;
	// Miss seen in cycle 0 and last fill word written in cycle 12
	localparam int MISS_STALL   = 13;
	localparam int RANDOM_OPS   = 40;
	// Directed accesses before the random test including both paired misses
	localparam int DIRECTED_OPS = 3 + 2 * WORDS_PER_BLOCK + 2 + 6;
	// Worst case with every access a miss
	localparam int TEST_CYCLES  = RESET_CYCLES + (MISS_STALL + 1) * (DIRECTED_OPS + RANDOM_OPS);

	typedef logic [ADDR_W-2:0] word_index_t;

	logic     clk;
	logic     reset;
	cpu_req_t instr_req;
	cpu_req_t data_req;
	word_t    instr_rdata;
	word_t    data_rdata;
	logic     instr_stall;
	logic     data_stall;

	integer seed = 32'h19d6fbd1;
	int     checks;
	int     errors;

	// Reference state with cache 0 for instructions and cache 1 for data
	word_t mem_model [word_index_t];
	tag_t  model_tag   [2][NUM_SETS][NUM_WAYS];
	bit    model_valid [2][NUM_SETS][NUM_WAYS];
	bit    model_lru   [2][NUM_SETS];

	memory_system memory_system_inst (
		.clk         (clk),
		.reset       (reset),
		.instr_req   (instr_req),
		.instr_rdata (instr_rdata),
		.instr_stall (instr_stall),
		.data_req    (data_req),
		.data_rdata  (data_rdata),
		.data_stall  (data_stall)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Unwritten words read as zero
	function automatic word_t model_read(addr_t a);
		if (mem_model.exists(a[15:1])) begin
			return mem_model[a[15:1]];
		end
		return '0;
	endfunction

	// Way holding the block or -1 on a miss
	function automatic int model_way(int c, addr_t a);
		for (int w = 0; w < NUM_WAYS; w++) begin
			if (model_valid[c][a[9:4]][w] && model_tag[c][a[9:4]][w] == a[15:10]) begin
				return w;
			end
		end
		return -1;
	endfunction

	// Install on a miss and then make the used way most recent
	task automatic model_touch(int c, addr_t a);
		int w;
		w = model_way(c, a);
		if (w < 0) begin
			// Empty way 0, then empty way 1, then LRU
			if (!model_valid[c][a[9:4]][0]) begin
				w = 0;
			end else if (!model_valid[c][a[9:4]][1]) begin
				w = 1;
			end else begin
				w = model_lru[c][a[9:4]] ? 1 : 0;
			end
			model_valid[c][a[9:4]][w] = 1'b1;
			model_tag[c][a[9:4]][w]   = a[15:10];
		end
		model_lru[c][a[9:4]] = (w == 0);
	endtask

	task automatic compare_data(string what, addr_t a, word_t got, word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("error: time %0t: %s word at 0x%04h is 0x%04h, expected 0x%04h",
				$time, what, a, got, exp);
		end
	endtask

	task automatic expect_stall(string what, addr_t a, int got, int exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("error: time %0t: %s access at 0x%04h stalled %0d cycles, expected %0d",
				$time, what, a, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// Port drivers
	//////////////////////////////////////////////////

	// Hold one request until the stall sampled at the falling edge is low
	task automatic port_access(input bit on_instr, input bit wr, input addr_t a,
		input word_t wd, output word_t rd, output int stall_cycles);
		cpu_req_t req;
		bit       done;
		req.read  = ~wr;
		req.write = wr;
		req.addr  = a;
		req.wdata = wd;
		if (on_instr) begin
			instr_req = req;
		end else begin
			data_req = req;
		end
		stall_cycles = 0;
		done         = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (on_instr ? instr_stall : data_stall) begin
				stall_cycles++;
			end else begin
				rd   = on_instr ? instr_rdata : data_rdata;
				done = 1'b1;
			end
			@(posedge clk);
			#(DRIVE_DELAY);
		end
		// Access completed at the edge just passed
		instr_req = on_instr ? '0 : instr_req;
		data_req  = on_instr ? data_req : '0;
	endtask

	// One access checked against the model's hit and data prediction
	task automatic run_access(input bit on_instr, input bit wr, input addr_t a,
		input word_t wd, output int stall_cycles);
		int    c;
		int    exp_stall;
		word_t rd;
		string port;
		c         = on_instr ? 0 : 1;
		port      = on_instr ? "instruction" : "data";
		exp_stall = (model_way(c, a) < 0) ? MISS_STALL : 0;
		port_access(on_instr, wr, a, wd, rd, stall_cycles);
		expect_stall(port, a, stall_cycles, exp_stall);
		if (!wr) begin
			compare_data(port, a, rd, model_read(a));
		end
		model_touch(c, a);
		if (wr) begin
			mem_model[a[15:1]] = wd;
		end
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic miss_then_hit();
		addr_t       a;
		logic [31:0] rnd;
		int          st;
		a   = {6'h05, 6'h01, 3'd2, 1'b0};
		rnd = $random(seed);
		// Cold store fills the block and writes through
		run_access(1'b0, 1'b1, a, rnd[15:0], st);
		compare_data("memory", a, memory_system_inst.main_memory_inst.mem_array[a[15:1]],
			rnd[15:0]);
		run_access(1'b0, 1'b0, a, '0, st);
		run_access(1'b0, 1'b0, {a[15:4], 3'd5, 1'b0}, '0, st);
	endtask

	task automatic instr_block_fill();
		addr_t       base;
		logic [31:0] rnd;
		int          st;
		base = {6'h09, 6'h02, 4'h0};
		for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
			rnd = $random(seed);
			run_access(1'b0, 1'b1, {base[15:4], offset_t'(w), 1'b0}, rnd[15:0], st);
		end
		// First fetch fills from memory and the rest hit
		for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
			run_access(1'b1, 1'b0, {base[15:4], offset_t'(w), 1'b0}, '0, st);
		end
	endtask

	task automatic port_arbitration();
		addr_t    ia;
		addr_t    da;
		word_t    ird;
		word_t    drd;
		int       ist;
		int       dst;
		bit       idone;
		bit       ddone;
		cpu_req_t req;
		// Instruction side reads the block stored by the first test
		ia        = {6'h05, 6'h01, 4'h4};
		da        = {6'h13, 6'h03, 4'h6};
		req       = '0;
		req.read  = 1'b1;
		req.addr  = ia;
		instr_req = req;
		req.addr  = da;
		data_req  = req;
		ist       = 0;
		dst       = 0;
		idone     = 1'b0;
		ddone     = 1'b0;
		while (!(idone && ddone)) begin
			@(negedge clk);
			if (!idone) begin
				if (instr_stall) begin
					ist++;
				end else begin
					ird   = instr_rdata;
					idone = 1'b1;
				end
			end
			if (!ddone) begin
				if (data_stall) begin
					dst++;
				end else begin
					drd   = data_rdata;
					ddone = 1'b1;
				end
			end
			@(posedge clk);
			#(DRIVE_DELAY);
			instr_req = idone ? '0 : instr_req;
			data_req  = ddone ? '0 : data_req;
		end
		// Data fill waits behind the whole instruction fill
		expect_stall("instruction", ia, ist, MISS_STALL);
		expect_stall("data", da, dst, 2 * MISS_STALL);
		compare_data("instruction", ia, ird, model_read(ia));
		compare_data("data", da, drd, model_read(da));
		model_touch(0, ia);
		model_touch(1, da);
	endtask

	task automatic lru_replacement();
		addr_t       t1;
		addr_t       t2;
		addr_t       t3;
		logic [31:0] rnd;
		int          st;
		t1  = {6'h21, 6'h07, 4'h2};
		t2  = {6'h22, 6'h07, 4'h8};
		t3  = {6'h23, 6'h07, 4'hc};
		rnd = $random(seed);
		run_access(1'b0, 1'b1, t1, rnd[15:0], st);
		run_access(1'b0, 1'b1, t2, rnd[31:16], st);
		// t1 used again so t2 becomes the victim
		run_access(1'b0, 1'b0, t1, '0, st);
		rnd = $random(seed);
		run_access(1'b0, 1'b1, t3, rnd[15:0], st);
		run_access(1'b0, 1'b0, t1, '0, st);
		expect_stall("data", t1, st, 0);
		run_access(1'b0, 1'b0, t2, '0, st);
		expect_stall("data", t2, st, MISS_STALL);
	endtask

	task automatic random_write_through();
		addr_t       a;
		logic [31:0] rnd;
		int          st;
		for (int i = 0; i < RANDOM_OPS; i++) begin
			rnd = $random(seed);
			// Four tags over four sets make both ways fill and evict
			a = {4'hc, rnd[1:0], 4'h2, rnd[3:2], rnd[6:4], 1'b0};
			run_access(1'b0, rnd[7], a, rnd[31:16], st);
		end
		// Every word the model knows about must sit in main memory
		foreach (mem_model[k]) begin
			compare_data("memory", {k, 1'b0},
				memory_system_inst.main_memory_inst.mem_array[k], mem_model[k]);
		end
	endtask

	//////////////////////////////////////////////////
	// Sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		clk       = 1'b0;
		reset     = 1'b1;
		instr_req = '0;
		data_req  = '0;
		checks    = 0;
		errors    = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#(DRIVE_DELAY);
		reset = 1'b0;
		miss_then_hit();
		instr_block_fill();
		port_arbitration();
		lru_replacement();
		random_write_through();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	initial begin
		#(TEST_CYCLES * CLK_PERIOD * 2);
		$display("Watchdog expired before the tests finished, checks run: %0d, errors: %0d",
			checks, errors);
		$display("Verification failed");
		$finish;
	end

endmodule

//--- sim.f
cache_pkg.sv
set_assoc_cache.sv
cache_fill_fsm.sv
main_memory.sv
memory_system.sv
memory_system_assertions.sv
tb_memory_system.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cache subsystem testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_memory_system \
	-f sim.f -o tb_memory_system > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_memory_system > sim.log 2>&1 \
	|| echo "Simulator exited with an error status" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && { echo "Test run FAILED"; exit 1; }
grep -q "Verification passed" sim.log || { echo "Test run FAILED, no result line"; exit 1; }
echo "Test run PASSED"
exit 0
